// ==== cornet_bus_pkg.sv ====
// ----------------------------------------------------------------------
// Cornet memory-side types: core data requests, responses, write trace
// ----------------------------------------------------------------------

package cornet_bus_pkg;

   // one strobe at a time, each a single-cycle pulse
   typedef struct packed {
      logic        rd_byte;
      logic        rd_word;
      logic        wr_en;
      logic [15:0] addr;
      logic [7:0]  wr_data;
   } data_req_t;

   typedef struct packed {
      logic        ack;         // pulse, read data valid
      logic [7:0]  byte_data;
      logic [15:0] word_data;   // low byte from addr, high from addr+1
   } data_rsp_t;

   // write strobe as seen on the memory bus
   typedef struct packed {
      logic        valid;
      logic [15:0] addr;
      logic [7:0]  data;
   } mem_write_t;

endpackage

// ==== cornet_bus_unit.sv ====
// ----------------------------------------------------------------------
// Cornet bus unit: puts opcode fetches, byte and word reads and writes
// from the core onto the single memory bus, fetches first
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cornet_bus_unit (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      fetch_req,
   input  logic [15:0]               fetch_addr,
   output logic                      fetch_ack,
   output logic [7:0]                fetch_data,
   input  cornet_bus_pkg::data_req_t data_req,
   output cornet_bus_pkg::data_rsp_t data_rsp,
   output logic [15:0]               addr,
   output logic                      rd_req,
   input  logic [7:0]                rd_data,
   input  logic                      ready,
   output logic                      wr_en,
   output logic [7:0]                wr_data
);

   typedef enum logic [2:0] {
      BUS_IDLE,
      BUS_BYTE,
      BUS_WORD_L,
      BUS_WORD_H,
      BUS_FETCH
   } bus_state_e;

   bus_state_e  state;
   logic        fetch_pend;
   logic [15:0] fetch_addr_q;
   logic        rd_done;

   // memory answers once our request is gone and ready is back
   assign rd_done = ready && !rd_req;

   always_ff @(posedge clk)
   begin
      rd_req       <= 1'b0;
      wr_en        <= 1'b0;
      fetch_ack    <= 1'b0;
      data_rsp.ack <= 1'b0;
      if (fetch_req)
      begin
         fetch_pend   <= 1'b1;
         fetch_addr_q <= fetch_addr;
      end
      if (!reset_n)
      begin
         state      <= BUS_IDLE;
         fetch_pend <= 1'b0;
      end
      else
         case (state)
            BUS_IDLE:
               if (fetch_req || fetch_pend)
               begin
                  addr       <= fetch_req ? fetch_addr : fetch_addr_q;   // held until ack
                  rd_req     <= 1'b1;
                  fetch_pend <= 1'b0;
                  state      <= BUS_FETCH;
               end
               else if (data_req.rd_byte || data_req.rd_word)
               begin
                  addr   <= data_req.addr;
                  rd_req <= 1'b1;
                  state  <= data_req.rd_byte ? BUS_BYTE : BUS_WORD_L;
               end
               else if (data_req.wr_en)
               begin
                  addr    <= data_req.addr;
                  wr_data <= data_req.wr_data;
                  wr_en   <= 1'b1;
               end
            BUS_FETCH:
               if (rd_done)
               begin
                  fetch_data <= rd_data;
                  fetch_ack  <= 1'b1;
                  state      <= BUS_IDLE;
               end
            BUS_BYTE:
               if (rd_done)
               begin
                  data_rsp.byte_data <= rd_data;
                  data_rsp.ack       <= 1'b1;
                  state              <= BUS_IDLE;
               end
            BUS_WORD_L:
               if (rd_done)
               begin
                  data_rsp.word_data[7:0] <= rd_data;
                  addr                    <= addr + 16'd1;   // high byte next
                  rd_req                  <= 1'b1;
                  state                   <= BUS_WORD_H;
               end
            BUS_WORD_H:
               if (rd_done)
               begin
                  data_rsp.word_data[15:8] <= rd_data;
                  data_rsp.ack             <= 1'b1;
                  state                    <= BUS_IDLE;
               end
            default: state <= BUS_IDLE;
         endcase
   end

endmodule

// ==== cornet_cpu.sv ====
// ----------------------------------------------------------------------
// Cornet CPU core: minimal 6502 subset with sequencer, decoder and
// executor working on A, X, Y, M, PC and the zero flag
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cornet_cpu (
   input  logic                     clk,
   input  logic                     reset_n,
   output logic                     fetch_req,
   output logic [15:0]              fetch_addr,
   input  logic                     fetch_ack,
   input  logic [7:0]               fetch_data,
   output cornet_bus_pkg::data_req_t data_req,
   input  cornet_bus_pkg::data_rsp_t data_rsp
);

   import cornet_isa_pkg::*;

   seq_state_e  seq_state;
   inst_state_e inst_state;
   inst_state_e next_op;      // follow-up access requested by the executor
   opcode_e     reg_i;
   logic [15:0] pc;
   logic [15:0] pc_next;
   logic [15:0] pc_seq;
   logic [1:0]  pc_delta;     // instruction length
   logic [15:0] op_addr;      // effective address
   logic [7:0]  reg_a;
   logic [7:0]  reg_x;
   logic [7:0]  reg_y;
   logic [7:0]  reg_m;
   logic        flag_z;
   logic        inst_done;

   assign pc_seq = pc + {14'd0, pc_delta};

   // sequencer
   always_ff @(posedge clk)
   begin
      fetch_req <= 1'b0;
      if (!reset_n)
         seq_state <= SEQ_WAIT;
      else
         case (seq_state)
            SEQ_WAIT:  seq_state <= SEQ_RESET;
            SEQ_RESET: seq_state <= SEQ_EXECUTE_WAIT;   // vector read runs as an instruction
            SEQ_FETCH:
            begin
               fetch_req  <= 1'b1;
               fetch_addr <= pc;
               seq_state  <= SEQ_LOAD_INST;
            end
            SEQ_LOAD_INST:
               if (fetch_ack)
               begin
                  reg_i     <= opcode_e'(fetch_data);
                  seq_state <= SEQ_EXECUTE;
               end
            SEQ_EXECUTE: seq_state <= SEQ_EXECUTE_WAIT;
            SEQ_EXECUTE_WAIT:
               if (inst_done)
               begin
                  pc        <= pc_next;
                  seq_state <= SEQ_FETCH;
               end
            default: seq_state <= SEQ_WAIT;
         endcase
   end

   // decoder, issues operand and effective address accesses
   always_ff @(posedge clk)
   begin
      data_req.rd_byte <= 1'b0;
      data_req.rd_word <= 1'b0;
      data_req.wr_en   <= 1'b0;
      if (!reset_n)
         inst_state <= IS_NOP;
      else if (seq_state == SEQ_RESET)
      begin
         data_req.rd_word <= 1'b1;
         data_req.addr    <= RESET_VECTOR;
         inst_state       <= IS_RESET;
      end
      else if (seq_state == SEQ_EXECUTE)
      begin
         data_req.addr <= pc + 16'd1;   // operand follows the opcode
         case (reg_i)
            OP_JMP:       inst_state <= IS_JMP;
            OP_LDA_IMM:   inst_state <= IS_LDA;
            OP_LDX_IMM:   inst_state <= IS_LDX;
            OP_LDY_IMM:   inst_state <= IS_LDY;
            OP_LDA_Z:     inst_state <= IS_LDA_Z;
            OP_LDA_Z_Y:   inst_state <= IS_LDA_Z_Y;
            OP_LDA_ABS:   inst_state <= IS_LDA_ABS;
            OP_LDA_ABS_X: inst_state <= IS_LDA_ABS_X;
            OP_LDA_ABS_Y: inst_state <= IS_LDA_ABS_Y;
            OP_STA_Z:     inst_state <= IS_STA_Z;
            OP_STA_ABS:   inst_state <= IS_STA_ABS;
            OP_STA_ABS_X: inst_state <= IS_STA_ABS_X;
            OP_CMP_IMM:   inst_state <= IS_CMP;
            OP_CPX_IMM:   inst_state <= IS_CPX;
            OP_CPY_IMM:   inst_state <= IS_CPY;
            OP_INX:       inst_state <= IS_INX;
            OP_INY:       inst_state <= IS_INY;
            OP_INC_Z:     inst_state <= IS_INC_Z;
            OP_INC_ABS:   inst_state <= IS_INC_ABS;
            OP_BEQ:       inst_state <= flag_z ? IS_BRANCH : IS_NO_BRANCH;
            OP_BNE:       inst_state <= flag_z ? IS_NO_BRANCH : IS_BRANCH;
            default:      inst_state <= IS_NOP;   // unknown opcode
         endcase
         // operand size and instruction length
         case (reg_i)
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_LDA_Z, OP_LDA_Z_Y,
            OP_STA_Z, OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM, OP_INC_Z:
            begin
               data_req.rd_byte <= 1'b1;
               pc_delta         <= 2'd2;
            end
            OP_JMP, OP_LDA_ABS, OP_LDA_ABS_X, OP_LDA_ABS_Y,
            OP_STA_ABS, OP_STA_ABS_X, OP_INC_ABS:
            begin
               data_req.rd_word <= 1'b1;
               pc_delta         <= 2'd3;
            end
            OP_BEQ:
            begin
               data_req.rd_byte <= flag_z;   // offset only needed when taken
               pc_delta         <= 2'd2;
            end
            OP_BNE:
            begin
               data_req.rd_byte <= !flag_z;
               pc_delta         <= 2'd2;
            end
            default: pc_delta <= 2'd1;
         endcase
      end
      else if (seq_state == SEQ_FETCH)
         inst_state <= IS_NOP;
      else
         case (next_op)
            IS_LDA_Z_Y:
            begin
               data_req.rd_word <= 1'b1;   // pointer from zero page
               data_req.addr    <= op_addr;
               inst_state       <= IS_LDA_ABS_Y;
            end
            IS_LDA_ADDR:
            begin
               data_req.rd_byte <= 1'b1;
               data_req.addr    <= op_addr;
               inst_state       <= IS_LDA;
            end
            IS_INC_ADDR:
            begin
               data_req.rd_byte <= 1'b1;
               data_req.addr    <= op_addr;
               inst_state       <= IS_INC_ADDR;
            end
            IS_STA_ADDR:
            begin
               data_req.wr_en   <= 1'b1;
               data_req.addr    <= op_addr;
               data_req.wr_data <= reg_a;
               inst_state       <= IS_STA;
            end
            IS_STM_ADDR:
            begin
               data_req.wr_en   <= 1'b1;   // INC write back
               data_req.addr    <= op_addr;
               data_req.wr_data <= reg_m;
               inst_state       <= IS_STM;
            end
            default: ;
         endcase
   end

   // executor
   always_ff @(posedge clk)
   begin
      inst_done <= 1'b0;
      next_op   <= IS_NOP;
      if (reset_n && !inst_done && seq_state == SEQ_EXECUTE_WAIT)
      begin
         // no memory data needed
         case (inst_state)
            IS_NOP, IS_STA, IS_STM, IS_NO_BRANCH:
            begin
               pc_next   <= pc_seq;
               inst_done <= 1'b1;
            end
            IS_INX:
            begin
               reg_x     <= reg_x + 8'd1;
               flag_z    <= reg_x == 8'hFF;
               pc_next   <= pc_seq;
               inst_done <= 1'b1;
            end
            IS_INY:
            begin
               reg_y     <= reg_y + 8'd1;
               flag_z    <= reg_y == 8'hFF;
               pc_next   <= pc_seq;
               inst_done <= 1'b1;
            end
            default: ;
         endcase

         if (data_rsp.ack)
            case (inst_state)
               IS_RESET:
               begin
                  reg_a     <= 8'd0;
                  reg_x     <= 8'd0;
                  pc_next   <= data_rsp.word_data;
                  inst_done <= 1'b1;
               end
               IS_LDA:
               begin
                  reg_a     <= data_rsp.byte_data;
                  flag_z    <= data_rsp.byte_data == 8'd0;
                  pc_next   <= pc_seq;
                  inst_done <= 1'b1;
               end
               IS_LDX:
               begin
                  reg_x     <= data_rsp.byte_data;
                  pc_next   <= pc_seq;
                  inst_done <= 1'b1;
               end
               IS_LDY:
               begin
                  reg_y     <= data_rsp.byte_data;
                  pc_next   <= pc_seq;
                  inst_done <= 1'b1;
               end
               IS_CMP, IS_CPX, IS_CPY:
               begin
                  flag_z    <= data_rsp.byte_data == (inst_state == IS_CMP ? reg_a :
                                                      inst_state == IS_CPX ? reg_x : reg_y);
                  pc_next   <= pc_seq;
                  inst_done <= 1'b1;
               end
               IS_INC_ADDR:
               begin
                  reg_m   <= data_rsp.byte_data + 8'd1;
                  flag_z  <= data_rsp.byte_data == 8'hFF;
                  next_op <= IS_STM_ADDR;
               end
               IS_INC_Z:
               begin
                  op_addr <= {8'd0, data_rsp.byte_data};
                  next_op <= IS_INC_ADDR;
               end
               IS_INC_ABS:
               begin
                  op_addr <= data_rsp.word_data;
                  next_op <= IS_INC_ADDR;
               end
               IS_LDA_Z_Y:
               begin
                  op_addr <= {8'd0, data_rsp.byte_data};
                  next_op <= IS_LDA_Z_Y;
               end
               IS_LDA_Z:
               begin
                  op_addr <= {8'd0, data_rsp.byte_data};
                  next_op <= IS_LDA_ADDR;
               end
               IS_LDA_ABS:
               begin
                  op_addr <= data_rsp.word_data;
                  next_op <= IS_LDA_ADDR;
               end
               IS_LDA_ABS_X, IS_LDA_ABS_Y:
               begin
                  op_addr <= data_rsp.word_data +
                             {8'd0, inst_state == IS_LDA_ABS_X ? reg_x : reg_y};
                  next_op <= IS_LDA_ADDR;
               end
               IS_STA_Z:
               begin
                  op_addr <= {8'd0, data_rsp.byte_data};
                  next_op <= IS_STA_ADDR;
               end
               IS_STA_ABS:
               begin
                  op_addr <= data_rsp.word_data;
                  next_op <= IS_STA_ADDR;
               end
               IS_STA_ABS_X:
               begin
                  op_addr <= data_rsp.word_data + {8'd0, reg_x};
                  next_op <= IS_STA_ADDR;
               end
               IS_JMP:
               begin
                  pc_next   <= data_rsp.word_data;
                  inst_done <= 1'b1;
               end
               IS_BRANCH:
               begin
                  // signed offset relative to the next instruction
                  pc_next   <= pc + 16'd2 + {{8{data_rsp.byte_data[7]}}, data_rsp.byte_data};
                  inst_done <= 1'b1;
               end
               default: ;
            endcase
      end
   end

endmodule

// ==== cornet_isa_pkg.sv ====
// ----------------------------------------------------------------------
// Cornet ISA types for the opcode encodings and the executor and
// sequencer states
// ----------------------------------------------------------------------

package cornet_isa_pkg;

   localparam logic [15:0] RESET_VECTOR = 16'hFFFC;   // vector low byte with the high byte after it

   // 6502 encodings of the supported subset
   typedef enum logic [7:0] {
      OP_JMP       = 8'h4C,
      OP_STA_Z     = 8'h85,
      OP_STA_ABS   = 8'h8D,
      OP_STA_ABS_X = 8'h9D,
      OP_LDY_IMM   = 8'hA0,
      OP_LDX_IMM   = 8'hA2,
      OP_LDA_Z     = 8'hA5,
      OP_LDA_IMM   = 8'hA9,
      OP_LDA_ABS   = 8'hAD,
      OP_LDA_Z_Y   = 8'hB1,
      OP_LDA_ABS_Y = 8'hB9,
      OP_LDA_ABS_X = 8'hBD,
      OP_CPY_IMM   = 8'hC0,
      OP_INY       = 8'hC8,
      OP_CMP_IMM   = 8'hC9,
      OP_BNE       = 8'hD0,
      OP_CPX_IMM   = 8'hE0,
      OP_INC_Z     = 8'hE6,
      OP_INX       = 8'hE8,
      OP_INC_ABS   = 8'hEE,
      OP_BEQ       = 8'hF0
   } opcode_e;

   // micro-operation held by the executor
   typedef enum logic [5:0] {
      IS_NOP, IS_RESET, IS_JMP, IS_BRANCH, IS_NO_BRANCH,
      IS_LDA, IS_LDX, IS_LDY,
      IS_LDA_Z, IS_LDA_Z_Y, IS_LDA_ABS, IS_LDA_ABS_X, IS_LDA_ABS_Y, IS_LDA_ADDR,
      IS_INX, IS_INY, IS_CMP, IS_CPX, IS_CPY,
      IS_STA, IS_STA_Z, IS_STA_ABS, IS_STA_ABS_X, IS_STA_ADDR,
      IS_STM, IS_STM_ADDR,
      IS_INC_Z, IS_INC_ABS, IS_INC_ADDR
   } inst_state_e;

   typedef enum logic [2:0] {
      SEQ_WAIT,
      SEQ_RESET,
      SEQ_FETCH,
      SEQ_LOAD_INST,
      SEQ_EXECUTE,
      SEQ_EXECUTE_WAIT
   } seq_state_e;

endpackage

// ==== cornet_ram.sv ====
// ----------------------------------------------------------------------
// Cornet RAM: byte-wide synchronous memory with wait states on reads,
// a load port used in reset, upper address bits mirrored
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cornet_ram #(
   parameter int RAM_ADDR_BITS = 12,
   parameter int RAM_WAIT      = 1   // 0 to 3
) (
   input  logic        clk,
   input  logic        reset_n,
   input  logic [15:0] addr,
   input  logic        rd_req,
   output logic [7:0]  rd_data,
   output logic        ready,
   input  logic        wr_en,
   input  logic [7:0]  wr_data,
   input  logic        load_en,
   input  logic [15:0] load_addr,
   input  logic [7:0]  load_data
);

   logic [7:0] mem [2**RAM_ADDR_BITS];
   logic [1:0] wait_cnt;

   always_ff @(posedge clk)
   begin
      if (!reset_n && load_en)
         mem[load_addr[RAM_ADDR_BITS-1:0]] <= load_data;
      else if (wr_en)
         mem[addr[RAM_ADDR_BITS-1:0]] <= wr_data;
      if (rd_req)
         rd_data <= mem[addr[RAM_ADDR_BITS-1:0]];
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         wait_cnt <= 2'd0;
      else if (rd_req)
         wait_cnt <= 2'(RAM_WAIT);
      else if (wait_cnt != 2'd0)
         wait_cnt <= wait_cnt - 2'd1;
   end

   assign ready = wait_cnt == 2'd0;

endmodule

// ==== cornet_system.sv ====
// ----------------------------------------------------------------------
// Cornet test computer: core, bus unit and RAM on one memory bus
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cornet_system #(
   parameter int RAM_ADDR_BITS = 12,
   parameter int RAM_WAIT      = 1
) (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       load_en,
   input  logic [15:0]                load_addr,
   input  logic [7:0]                 load_data,
   output cornet_bus_pkg::mem_write_t write_trace
);

   import cornet_bus_pkg::*;

   logic        fetch_req;
   logic [15:0] fetch_addr;
   logic        fetch_ack;
   logic [7:0]  fetch_data;
   data_req_t   data_req;
   data_rsp_t   data_rsp;
   logic [15:0] mem_addr;
   logic        rd_req;
   logic [7:0]  rd_data;
   logic        ready;
   logic        wr_en;
   logic [7:0]  wr_data;

   assign write_trace = '{valid: wr_en, addr: mem_addr, data: wr_data};

   cornet_cpu cornet_cpu_inst (
      .clk        (clk),
      .reset_n    (reset_n),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .fetch_ack  (fetch_ack),
      .fetch_data (fetch_data),
      .data_req   (data_req),
      .data_rsp   (data_rsp)
   );

   cornet_bus_unit cornet_bus_unit_inst (
      .clk        (clk),
      .reset_n    (reset_n),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .fetch_ack  (fetch_ack),
      .fetch_data (fetch_data),
      .data_req   (data_req),
      .data_rsp   (data_rsp),
      .addr       (mem_addr),
      .rd_req     (rd_req),
      .rd_data    (rd_data),
      .ready      (ready),
      .wr_en      (wr_en),
      .wr_data    (wr_data)
   );

   cornet_ram #(
      .RAM_ADDR_BITS (RAM_ADDR_BITS),
      .RAM_WAIT      (RAM_WAIT)
   ) cornet_ram_inst (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr      (mem_addr),
      .rd_req    (rd_req),
      .rd_data   (rd_data),
      .ready     (ready),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cornet testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_cornet -o tb_cornet
./obj_dir/tb_cornet | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "testbench reported a failure, see sim.log"
   exit 1
fi
grep -q "SIMULATION PASSED" sim.log

// ==== sim.f ====
cornet_isa_pkg.sv
cornet_bus_pkg.sv
cornet_cpu.sv
cornet_bus_unit.sv
cornet_ram.sv
cornet_system.sv
tb_cornet.sv

// ==== tb_cornet.sv ====
// ----------------------------------------------------------------------
// Cornet testbench that runs random programs on the test computer and
// checks the memory writes against an instruction-level model
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_cornet;

   import cornet_isa_pkg::*;
   import cornet_bus_pkg::*;

   localparam int NUM_PROGS = 20;
   localparam int MEM_SIZE  = 4096;   // mirrored RAM window
   localparam int WAIT_MAX  = 2000;
   localparam int QUIET     = 300;

   localparam opcode_e TWO_BYTE_OPS [10] = '{
      OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_LDA_Z, OP_LDA_Z_Y,
      OP_STA_Z, OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM, OP_INC_Z
   };
   localparam opcode_e MIX_OPS [18] = '{
      OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_LDA_Z, OP_LDA_Z_Y,
      OP_STA_Z, OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM, OP_INC_Z,
      OP_INX, OP_INY, OP_LDA_ABS, OP_LDA_ABS_X, OP_LDA_ABS_Y,
      OP_STA_ABS, OP_STA_ABS_X, OP_INC_ABS
   };

   logic        clk;
   logic        reset_n;
   logic        load_en;
   logic [15:0] load_addr;
   logic [7:0]  load_data;
   mem_write_t  write_trace;

   logic [31:0] lcg_state;
   logic [7:0]  image [MEM_SIZE];       // RAM contents for one program
   logic [7:0]  model_mem [MEM_SIZE];
   logic [15:0] code_pc;
   mem_write_t  exp_q [$];

   cornet_system #(
      .RAM_ADDR_BITS (12),
      .RAM_WAIT      (1)
   ) cornet_system_inst (
      .clk         (clk),
      .reset_n     (reset_n),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .write_trace (write_trace)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [15:0] rand16();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   // values near 0 and FF so compares and increments reach zero
   function automatic logic [7:0] rand_imm();
      logic [15:0] r;
      r = rand16();
      return r[2] ? {6'h00, r[1:0]} : {6'h3F, r[1:0]};
   endfunction

   // store targets land in 000-7FE or F00-FFF after mirroring and never on code
   function automatic logic [15:0] rand_store_addr();
      logic [15:0] r;
      logic [15:0] s;
      r = rand16();
      s = rand16();
      if (r[1:0] == 2'd0)
         return {8'hFF, s[7:0]};   // index addition may wrap past FFFF
      return {s[15:12], 4'(r[15:4] % 7), s[7:0]};
   endfunction

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic put_code_byte(input logic [7:0] b);
      image[code_pc[11:0]] = b;
      code_pc = code_pc + 16'd1;
   endtask

   task automatic put_inst(input opcode_e op);
      logic [15:0] w;
      put_code_byte(op);
      case (op)
         OP_INX, OP_INY: ;
         OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM:
            put_code_byte(rand_imm());
         OP_LDA_Z, OP_LDA_Z_Y, OP_STA_Z, OP_INC_Z:
         begin
            w = rand16();
            put_code_byte(w[7:0]);
         end
         OP_STA_ABS, OP_STA_ABS_X, OP_INC_ABS:
         begin
            w = rand_store_addr();
            put_code_byte(w[7:0]);
            put_code_byte(w[15:8]);
         end
         default:
         begin
            w = rand16();   // loads may read anywhere
            put_code_byte(w[7:0]);
            put_code_byte(w[15:8]);
         end
      endcase
   endtask

   task automatic build_program();
      logic [15:0] r;
      logic [15:0] start;
      logic [15:0] jmp_at;
      int          skip;
      for (int i = 0; i < MEM_SIZE; i++)
      begin
         r = rand16();
         image[i] = r[7:0];
      end
      r       = rand16();
      start   = 16'h0800 + {8'd0, r[7:0]};
      code_pc = start;
      image[12'hFFC] = start[7:0];
      image[12'hFFD] = start[15:8];
      // A and X come from reset while Y and Z are set before any use
      put_inst(OP_STA_Z);
      put_inst(OP_STA_ABS_X);
      put_inst(OP_LDY_IMM);
      put_inst(OP_LDA_IMM);
      skip = 0;
      for (int n = 0; n < 24 || skip > 0; n++)
      begin
         r = rand16();
         if (skip > 0)
         begin
            put_inst(TWO_BYTE_OPS[r % 10]);
            skip--;
         end
         else if (r[15:13] == 3'd0)
         begin
            skip = int'(r[1:0]);   // forward over the next skip instructions
            put_code_byte(r[2] ? OP_BEQ : OP_BNE);
            put_code_byte(8'(2 * skip));
         end
         else
            put_inst(MIX_OPS[r % 18]);
      end
      jmp_at = code_pc;
      put_code_byte(OP_JMP);
      put_code_byte(jmp_at[7:0]);
      put_code_byte(jmp_at[15:8]);
   endtask

   function automatic logic [7:0] model_rd(input logic [15:0] a);
      return model_mem[a[11:0]];
   endfunction

   function automatic logic [15:0] model_rd_word(input logic [15:0] a);
      return {model_rd(a + 16'd1), model_rd(a)};
   endfunction

   task automatic model_wr(input logic [15:0] a, input logic [7:0] d);
      mem_write_t w;
      model_mem[a[11:0]] = d;
      w.valid = 1'b1;
      w.addr  = a;
      w.data  = d;
      exp_q.push_back(w);
   endtask

   // instruction-level model that fills exp_q with the expected writes
   task automatic run_model();
      opcode_e     op;
      logic [15:0] pc;
      logic [15:0] ea;
      logic [15:0] word;
      logic [7:0]  opnd;
      logic [7:0]  a;
      logic [7:0]  x;
      logic [7:0]  y;
      logic [7:0]  m;
      logic        z;
      logic        done;
      int          steps;
      for (int i = 0; i < MEM_SIZE; i++)
         model_mem[i] = image[i];
      exp_q.delete();
      pc    = model_rd_word(RESET_VECTOR);
      a     = 8'd0;
      x     = 8'd0;
      y     = 8'd0;
      z     = 1'b0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000)
      begin
         op   = opcode_e'(model_rd(pc));
         opnd = model_rd(pc + 16'd1);
         word = model_rd_word(pc + 16'd1);
         steps++;
         case (op)
            OP_LDA_Z, OP_STA_Z, OP_INC_Z: ea = {8'd0, opnd};
            OP_LDA_Z_Y: ea = model_rd_word({8'd0, opnd}) + {8'd0, y};
            OP_LDA_ABS_X, OP_STA_ABS_X: ea = word + {8'd0, x};
            OP_LDA_ABS_Y: ea = word + {8'd0, y};
            default: ea = word;
         endcase
         case (op)
            OP_LDA_IMM:
            begin
               a = opnd;
               z = a == 8'd0;
            end
            OP_LDA_Z, OP_LDA_Z_Y, OP_LDA_ABS, OP_LDA_ABS_X, OP_LDA_ABS_Y:
            begin
               a = model_rd(ea);
               z = a == 8'd0;
            end
            OP_LDX_IMM: x = opnd;   // zero flag kept
            OP_LDY_IMM: y = opnd;
            OP_STA_Z, OP_STA_ABS, OP_STA_ABS_X: model_wr(ea, a);
            OP_CMP_IMM: z = opnd == a;
            OP_CPX_IMM: z = opnd == x;
            OP_CPY_IMM: z = opnd == y;
            OP_INX:
            begin
               x = x + 8'd1;
               z = x == 8'd0;
            end
            OP_INY:
            begin
               y = y + 8'd1;
               z = y == 8'd0;
            end
            OP_INC_Z, OP_INC_ABS:
            begin
               m = model_rd(ea) + 8'd1;
               model_wr(ea, m);
               z = m == 8'd0;
            end
            default: ;
         endcase
         case (op)
            OP_JMP:
            begin
               done = ea == pc;
               pc   = ea;
            end
            OP_BEQ, OP_BNE:
               pc = pc + 16'd2 + (((op == OP_BEQ) == z) ? {{8{opnd[7]}}, opnd} : 16'd0);
            OP_INX, OP_INY: pc = pc + 16'd1;
            OP_LDA_ABS, OP_LDA_ABS_X, OP_LDA_ABS_Y, OP_STA_ABS, OP_STA_ABS_X, OP_INC_ABS:
               pc = pc + 16'd3;
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_LDA_Z, OP_LDA_Z_Y,
            OP_STA_Z, OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM, OP_INC_Z:
               pc = pc + 16'd2;
            default: pc = pc + 16'd1;   // unknown opcode acts as a NOP
         endcase
      end
      if (!done)
         stop_on_error("ERROR: reference model never reached the final JMP");
   endtask

   task automatic load_and_reset();
      @(posedge clk);
      #2;
      reset_n = 1'b0;
      for (int i = 0; i < MEM_SIZE; i++)
      begin
         load_en   = 1'b1;
         load_addr = 16'(i);
         load_data = image[i];
         @(posedge clk);
         #2;
      end
      load_en = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      reset_n = 1'b1;
   endtask

   task automatic wait_write(output mem_write_t act);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (write_trace.valid !== 1'b1 && cycles < WAIT_MAX)
      begin
         @(negedge clk);
         cycles++;
      end
      if (write_trace.valid !== 1'b1)
         stop_on_error("ERROR: processor stopped producing writes (2000-cycle timeout)");
      act = write_trace;
   endtask

   task automatic check_write(input mem_write_t act, input mem_write_t exp);
      if (act.addr !== exp.addr)
         stop_on_error($sformatf("FAILED time %0t write_trace.addr expected %h actual %h",
                                 $time, exp.addr, act.addr));
      if (act.data !== exp.data)
         stop_on_error($sformatf("FAILED time %0t write_trace.data expected %h actual %h",
                                 $time, exp.data, act.data));
   endtask

   // the final JMP loops on itself without writing
   task automatic check_quiet();
      for (int i = 0; i < QUIET; i++)
      begin
         @(negedge clk);
         if (write_trace.valid === 1'b1)
            stop_on_error($sformatf("ERROR: unexpected extra write to %h at time %0t",
                                    write_trace.addr, $time));
      end
   endtask

   initial
   begin
      mem_write_t act;
      int         total;
      lcg_state = 32'h36996418;
      reset_n   = 1'b0;
      load_en   = 1'b0;
      load_addr = 16'd0;
      load_data = 8'd0;
      total     = 0;
      for (int p = 0; p < NUM_PROGS; p++)
      begin
         build_program();
         run_model();
         load_and_reset();
         while (exp_q.size() > 0)
         begin
            wait_write(act);
            check_write(act, exp_q.pop_front());
            total++;
         end
         check_quiet();
      end
      $display("%0d writes checked over %0d programs", total, NUM_PROGS);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
